// File: sources.f
common/tap_pkg.sv
common/dr_pkg.sv
logic/scan_dr.sv
logic/tdo_mux.sv
tap/tap_fsm.sv
tap/tap_ir.sv
tap/stap_top.sv
+incdir+test
test/stap_tb.sv

// File: test/stap_tb_tasks.svh
`ifndef STAP_TB_TASKS_SVH
`define STAP_TB_TASKS_SVH

// --------------------
// JTAG pin driving
// --------------------

// One TCK cycle that samples TDO at the edge consuming TMS and TDI
task automatic clock_bit(input logic tms, input logic tdi, output logic tdo);
    ftap_tms <= tms;
    ftap_tdi <= tdi;
    @(posedge ftap_tck);
    tdo = ftap_tdo;
endtask

// Walks from Run-Test/Idle with capture on the last edge
task automatic to_shift_dr();
    logic unused;
    clock_bit(1'b1, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
endtask

task automatic to_shift_ir();
    logic unused;
    clock_bit(1'b1, 1'b0, unused);
    clock_bit(1'b1, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
endtask

// LSB first with TMS high on the last bit to move on to Exit1
// TDO enable must be high for every bit of a shift
task automatic shift_bits(input int n, input logic [31:0] bits_in, output logic [31:0] bits_out);
    logic bit_out;
    bits_out = '0;
    for (int i = 0; i < n; i++) begin
        clock_bit(i == n - 1, bits_in[i], bit_out);
        bits_out[i] = bit_out;
        check_bit("tdoen in shift", 1'b1, ftap_tdoen);
    end
endtask

// Exit1 to Update, then Run-Test/Idle plus one idle cycle so updates settle
task automatic to_idle();
    logic unused;
    clock_bit(1'b1, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
    clock_bit(1'b0, 1'b0, unused);
endtask

task automatic dr_scan(input int n, input logic [31:0] bits_in, output logic [31:0] bits_out);
    to_shift_dr();
    shift_bits(n, bits_in, bits_out);
    to_idle();
endtask

task automatic ir_scan(input ir_t op, output ir_t captured);
    logic [31:0] bits_out;
    to_shift_ir();
    shift_bits(IR_WIDTH, 32'(op), bits_out);
    to_idle();
    captured = ir_t'(bits_out);
endtask

// --------------------
// Reference model
// --------------------

function automatic idcode_t expected_idcode();
    return IDCODE_VALUE;
endfunction

function automatic ir_t expected_ir_capture();
    return 4'b0001;
endfunction

// Contents of the control TDR after capture and n shifts toward the LSB
function automatic ctrl_tdr_t expected_ctrl(input ctrl_tdr_t cap, input logic [31:0] tdi,
                                            input int n);
    ctrl_tdr_t r;
    r = cap;
    for (int i = 0; i < n; i++) begin
        r = {tdi[i], r[$bits(ctrl_tdr_t)-1:1]};
    end
    return r;
endfunction

// Bypass captures zero, then echoes TDI one bit late
function automatic logic [31:0] expected_bypass(input logic [31:0] tdi);
    return {tdi[30:0], 1'b0};
endfunction

// --------------------
// Compare tasks
// --------------------

task automatic check_idcode(input string name, input idcode_t exp, input idcode_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_ir(input string name, input ir_t exp, input ir_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_tdr(input string name, input ctrl_tdr_t exp, input ctrl_tdr_t act);
    if (act !== exp) begin
        err_cnt++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        err_cnt++;
        $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
endtask

// One line per finished test
task automatic report_test(input string name, input int errs_at_start);
    if (err_cnt == errs_at_start) begin
        pass_cnt++;
        $display("test %s: pass", name);
    end else begin
        fail_cnt++;
        $display("test %s: fail, %0d failed checks", name, err_cnt - errs_at_start);
    end
endtask

`endif

// File: test/stap_tb.sv
`timescale 1ns/100ps

module stap_tb import tap_pkg::*, dr_pkg::*; ();

    // Clock period and run budget
    localparam int CLK_PERIOD  = 8;
    // Bits shifted over all five tests
    localparam int SHIFT_BITS  = 186;
    // TMS walks, idle cycles and reset come to about 7 per scan
    localparam int WALK_CYCLES = 100;
    localparam int TIMEOUT_NS  = (SHIFT_BITS + WALK_CYCLES) * CLK_PERIOD * 2;

    // DUT pins
    logic      ftap_tck;
    logic      arst_n;
    logic      ftap_tms;
    logic      ftap_tdi;
    logic      ftap_tdo;
    logic      ftap_tdoen;
    ctrl_tdr_t tdr_data_in;
    ctrl_tdr_t tdr_data_out;

    // Bookkeeping
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          errs_before;
    tap_state_t  fsm_state;

    // Scan data
    logic [31:0] din;
    logic [31:0] dout;
    logic [31:0] exp_bits;
    logic [31:0] stream;
    logic        tdo_bit;
    ir_t         ir_cap;
    ir_t         ops [2];
    ctrl_tdr_t   rd;
    ctrl_tdr_t   wr;
    ctrl_tdr_t   last_tdr;

    `include "stap_tb_tasks.svh"

    stap_top i_stap_top (
        .ftap_tck     (ftap_tck),
        .arst_n       (arst_n),
        .ftap_tms     (ftap_tms),
        .ftap_tdi     (ftap_tdi),
        .ftap_tdo     (ftap_tdo),
        .ftap_tdoen   (ftap_tdoen),
        .tdr_data_in  (tdr_data_in),
        .tdr_data_out (tdr_data_out)
    );

    // --------------------
    // Clock and watchdog
    // --------------------

    initial begin
        ftap_tck = 1'b0;
        forever #(CLK_PERIOD / 2) ftap_tck = ~ftap_tck;
    end

    initial begin
        #(TIMEOUT_NS);
        fsm_state = i_stap_top.i_tap_fsm.state;
        $display("Watchdog timeout after %0d ns, TAP controller stuck in %s",
                 TIMEOUT_NS, fsm_state.name());
        $display("*** TEST FAILED ***");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        void'($urandom(32'h64e9_f3c1));
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        arst_n      = 1'b0;
        ftap_tms    = 1'b1;
        ftap_tdi    = 1'b0;
        tdr_data_in = '0;
        repeat (5) @(posedge ftap_tck);
        arst_n <= 1'b1;

        // Test 1 checks IDCODE as the default instruction after reset
        errs_before = err_cnt;
        check_bit("tdoen after reset", 1'b0, ftap_tdoen);
        check_bit("tdo after reset", 1'b0, ftap_tdo);
        check_tdr("tdr_data_out after reset", '0, tdr_data_out);
        clock_bit(1'b0, 1'b0, tdo_bit);
        din = $urandom;
        dr_scan(32, din, dout);
        check_idcode("idcode after reset", expected_idcode(), idcode_t'(dout));
        check_bit("tdoen in idle", 1'b0, ftap_tdoen);
        check_bit("tdo in idle", 1'b0, ftap_tdo);
        report_test("idcode after reset", errs_before);

        // Test 2 reads the Capture-IR pattern
        errs_before = err_cnt;
        ir_scan(OP_IDCODE, ir_cap);
        check_ir("ir capture", expected_ir_capture(), ir_cap);
        report_test("ir capture", errs_before);

        // Test 3 writes the control TDR and reads back the core side input
        errs_before = err_cnt;
        ir_scan(OP_CTRL_TDR, ir_cap);
        wr = ctrl_tdr_t'($urandom);
        dr_scan(16, 32'(wr), dout);
        last_tdr = expected_ctrl(tdr_data_in, 32'(wr), 16);
        check_tdr("ctrl tdr update", last_tdr, tdr_data_out);
        rd = ctrl_tdr_t'($urandom);
        tdr_data_in <= rd;
        wr = ctrl_tdr_t'($urandom);
        dr_scan(16, 32'(wr), dout);
        check_tdr("ctrl tdr read-back", rd, ctrl_tdr_t'(dout));
        last_tdr = expected_ctrl(rd, 32'(wr), 16);
        check_tdr("ctrl tdr second update", last_tdr, tdr_data_out);
        report_test("control tdr", errs_before);

        // Test 4 runs bypass by its own opcode and by an undefined one
        errs_before = err_cnt;
        ops[0] = OP_BYPASS;
        do begin
            ops[1] = ir_t'($urandom);
        end while (ops[1] == OP_IDCODE || ops[1] == OP_CTRL_TDR || ops[1] == OP_BYPASS);
        for (int k = 0; k < 2; k++) begin
            ir_scan(ops[k], ir_cap);
            din = $urandom;
            dr_scan(32, din, dout);
            exp_bits = expected_bypass(din);
            for (int i = 0; i < 32; i++) begin
                check_bit($sformatf("bypass op %h bit %0d", ops[k], i), exp_bits[i], dout[i]);
            end
        end
        report_test("bypass", errs_before);

        // Test 5 escapes from Shift-DR to Test-Logic-Reset by TMS
        errs_before = err_cnt;
        ir_scan(OP_CTRL_TDR, ir_cap);
        rd = ctrl_tdr_t'($urandom);
        tdr_data_in <= rd;
        to_shift_dr();
        stream = $urandom;
        for (int i = 0; i < 5; i++) begin
            clock_bit(1'b0, stream[i], tdo_bit);
        end
        // Leaving Shift-DR shifts once more, then Update-DR fires on the way out
        stream[5] = 1'b0;
        repeat (5) clock_bit(1'b1, 1'b0, tdo_bit);
        last_tdr = expected_ctrl(rd, stream, 6);
        clock_bit(1'b0, 1'b0, tdo_bit);
        din = $urandom;
        dr_scan(32, din, dout);
        check_idcode("idcode after escape", expected_idcode(), idcode_t'(dout));
        check_tdr("tdr_data_out held", last_tdr, tdr_data_out);
        report_test("reset by tms", errs_before);

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tap/stap_top.sv
`timescale 1ns/100ps

module stap_top import dr_pkg::*; (
    input  logic      ftap_tck,
    input  logic      arst_n,
    input  logic      ftap_tms,
    input  logic      ftap_tdi,
    output logic      ftap_tdo,
    output logic      ftap_tdoen,
    input  ctrl_tdr_t tdr_data_in,
    output ctrl_tdr_t tdr_data_out
);

    // Controller strobes
    logic tlr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    // Instruction decode and serial outputs
    logic sel_idcode;
    logic sel_ctrl;
    logic ir_so;
    logic idcode_so;
    logic ctrl_so;

    // --------------------
    // Controller and IR
    // --------------------

    tap_fsm i_tap_fsm (
        .ftap_tck   (ftap_tck),
        .arst_n     (arst_n),
        .ftap_tms   (ftap_tms),
        .tlr        (tlr),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr)
    );

    tap_ir i_tap_ir (
        .ftap_tck   (ftap_tck),
        .arst_n     (arst_n),
        .ftap_tdi   (ftap_tdi),
        .tlr        (tlr),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .ir_so      (ir_so),
        .sel_idcode (sel_idcode),
        .sel_ctrl   (sel_ctrl)
    );

    // --------------------
    // Data registers
    // --------------------

    // IDCODE is read only, update stage unused
    scan_dr #(.payload_t(idcode_t)) i_idcode_dr (
        .ftap_tck(ftap_tck), .arst_n(arst_n), .sel(sel_idcode),
        .capture_dr(capture_dr), .shift_dr(shift_dr), .update_dr(update_dr),
        .si(ftap_tdi), .par_in(IDCODE_VALUE), .par_out(), .so(idcode_so)
    );

    // Control TDR with parallel ports to the core
    scan_dr #(.payload_t(ctrl_tdr_t)) i_ctrl_dr (
        .ftap_tck(ftap_tck), .arst_n(arst_n), .sel(sel_ctrl),
        .capture_dr(capture_dr), .shift_dr(shift_dr), .update_dr(update_dr),
        .si(ftap_tdi), .par_in(tdr_data_in), .par_out(tdr_data_out), .so(ctrl_so)
    );

    // Bypass and TDO retiming
    tdo_mux i_tdo_mux (
        .ftap_tck(ftap_tck), .arst_n(arst_n), .ftap_tdi(ftap_tdi),
        .shift_ir(shift_ir), .capture_dr(capture_dr), .shift_dr(shift_dr),
        .sel_idcode(sel_idcode), .sel_ctrl(sel_ctrl), .ir_so(ir_so),
        .idcode_so(idcode_so), .ctrl_so(ctrl_so),
        .ftap_tdo(ftap_tdo), .ftap_tdoen(ftap_tdoen)
    );

endmodule

// File: tap/tap_ir.sv
`timescale 1ns/100ps

module tap_ir import tap_pkg::*; (
    input  logic ftap_tck,
    input  logic arst_n,
    input  logic ftap_tdi,
    input  logic tlr,
    input  logic capture_ir,
    input  logic shift_ir,
    input  logic update_ir,
    output logic ir_so,
    output logic sel_idcode,
    output logic sel_ctrl
);

    ir_t ir_shift;
    ir_t ir_upd;

    // Shift stage
    // Capture pattern first, then TDI enters at the MSB
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            ir_shift <= IR_CAPTURE;
        end else if (capture_ir) begin
            ir_shift <= IR_CAPTURE;
        end else if (shift_ir) begin
            ir_shift <= {ftap_tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    // Serial out from the LSB end
    assign ir_so = ir_shift[0];

    // Update stage
    // Test-Logic-Reset keeps IDCODE as the active instruction
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            ir_upd <= OP_IDCODE;
        end else if (tlr) begin
            ir_upd <= OP_IDCODE;
        end else if (update_ir) begin
            ir_upd <= ir_shift;
        end
    end

    // --------------------
    // Instruction decode
    // --------------------

    // Undefined opcodes end up on the bypass register
    always_comb begin
        sel_idcode = 1'b0;
        sel_ctrl   = 1'b0;
        case (ir_upd)
            OP_IDCODE:   sel_idcode = 1'b1;
            OP_CTRL_TDR: sel_ctrl   = 1'b1;
            OP_BYPASS:   ;
            default:     ;
        endcase
    end

endmodule

// File: tap/tap_fsm.sv
`timescale 1ns/100ps

module tap_fsm import tap_pkg::*; (
    input  logic ftap_tck,
    input  logic arst_n,
    input  logic ftap_tms,
    output logic tlr,
    output logic capture_ir,
    output logic shift_ir,
    output logic update_ir,
    output logic capture_dr,
    output logic shift_dr,
    output logic update_dr
);

    tap_state_t state;
    tap_state_t state_nxt;

    // --------------------
    // State register
    // --------------------

    // TRST drops the controller straight into Test-Logic-Reset
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_TLR;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------
    // Next state table
    // --------------------

    always_comb begin
        unique case (state)
            // Idle side
            ST_TLR:        state_nxt = ftap_tms ? ST_TLR       : ST_RTI;
            ST_RTI:        state_nxt = ftap_tms ? ST_SEL_DR    : ST_RTI;
            // DR column
            ST_SEL_DR:     state_nxt = ftap_tms ? ST_SEL_IR    : ST_CAPTURE_DR;
            ST_CAPTURE_DR: state_nxt = ftap_tms ? ST_EXIT1_DR  : ST_SHIFT_DR;
            ST_SHIFT_DR:   state_nxt = ftap_tms ? ST_EXIT1_DR  : ST_SHIFT_DR;
            ST_EXIT1_DR:   state_nxt = ftap_tms ? ST_UPDATE_DR : ST_PAUSE_DR;
            ST_PAUSE_DR:   state_nxt = ftap_tms ? ST_EXIT2_DR  : ST_PAUSE_DR;
            ST_EXIT2_DR:   state_nxt = ftap_tms ? ST_UPDATE_DR : ST_SHIFT_DR;
            ST_UPDATE_DR:  state_nxt = ftap_tms ? ST_SEL_DR    : ST_RTI;
            // IR column, Select-IR with TMS high escapes to reset
            ST_SEL_IR:     state_nxt = ftap_tms ? ST_TLR       : ST_CAPTURE_IR;
            ST_CAPTURE_IR: state_nxt = ftap_tms ? ST_EXIT1_IR  : ST_SHIFT_IR;
            ST_SHIFT_IR:   state_nxt = ftap_tms ? ST_EXIT1_IR  : ST_SHIFT_IR;
            ST_EXIT1_IR:   state_nxt = ftap_tms ? ST_UPDATE_IR : ST_PAUSE_IR;
            ST_PAUSE_IR:   state_nxt = ftap_tms ? ST_EXIT2_IR  : ST_PAUSE_IR;
            ST_EXIT2_IR:   state_nxt = ftap_tms ? ST_UPDATE_IR : ST_SHIFT_IR;
            ST_UPDATE_IR:  state_nxt = ftap_tms ? ST_SEL_DR    : ST_RTI;
            default:       state_nxt = ST_TLR;
        endcase
    end

    // --------------------
    // Strobe decode
    // --------------------

    // Plain state decode, the registers act on the edge leaving the state
    assign tlr        = (state == ST_TLR);
    assign capture_ir = (state == ST_CAPTURE_IR);
    assign shift_ir   = (state == ST_SHIFT_IR);
    assign update_ir  = (state == ST_UPDATE_IR);
    assign capture_dr = (state == ST_CAPTURE_DR);
    assign shift_dr   = (state == ST_SHIFT_DR);
    assign update_dr  = (state == ST_UPDATE_DR);

endmodule

// File: logic/tdo_mux.sv
`timescale 1ns/100ps

module tdo_mux (
    input  logic ftap_tck,
    input  logic arst_n,
    input  logic ftap_tdi,
    input  logic shift_ir,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic sel_idcode,
    input  logic sel_ctrl,
    input  logic ir_so,
    input  logic idcode_so,
    input  logic ctrl_so,
    output logic ftap_tdo,
    output logic ftap_tdoen
);

    logic sel_bypass;
    logic bypass_q;
    logic dr_so;
    logic tdo_src;

    // Bypass owns any instruction without its own register
    assign sel_bypass = ~sel_idcode & ~sel_ctrl;

    // One-bit bypass, captures zero then follows TDI
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            bypass_q <= 1'b0;
        end else if (sel_bypass && capture_dr) begin
            bypass_q <= 1'b0;
        end else if (sel_bypass && shift_dr) begin
            bypass_q <= ftap_tdi;
        end
    end

    // --------------------
    // Source select
    // --------------------

    assign dr_so   = sel_idcode ? idcode_so : (sel_ctrl ? ctrl_so : bypass_q);
    assign tdo_src = shift_ir ? ir_so : dr_so;

    // Falling edge launch, host samples on the next rising edge
    // TDO parks low outside the shift states
    always_ff @(negedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            ftap_tdo   <= 1'b0;
            ftap_tdoen <= 1'b0;
        end else begin
            ftap_tdo   <= (shift_ir | shift_dr) & tdo_src;
            ftap_tdoen <= shift_ir | shift_dr;
        end
    end

endmodule

// File: logic/scan_dr.sv
`timescale 1ns/100ps

module scan_dr #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     ftap_tck,
    input  logic     arst_n,
    input  logic     sel,
    input  logic     capture_dr,
    input  logic     shift_dr,
    input  logic     update_dr,
    input  logic     si,
    input  payload_t par_in,
    output payload_t par_out,
    output logic     so
);

    // Register length follows the payload
    localparam int unsigned W = $bits(payload_t);

    logic [W-1:0] shift_q;

    // --------------------
    // Shift stage
    // --------------------

    // Parallel load on capture, LSB-first shift toward bit 0
    always_ff @(posedge ftap_tck) begin
        if (sel && capture_dr) begin
            shift_q <= par_in;
        end else if (sel && shift_dr) begin
            shift_q <= {si, shift_q[W-1:1]};
        end
    end

    assign so = shift_q[0];

    // --------------------
    // Update stage
    // --------------------

    // Core side only sees new data after Update-DR
    always_ff @(posedge ftap_tck or negedge arst_n) begin
        if (!arst_n) begin
            par_out <= '0;
        end else if (sel && update_dr) begin
            par_out <= payload_t'(shift_q);
        end
    end

endmodule

// File: common/dr_pkg.sv
package dr_pkg;

    // Payload widths of the two data registers
    localparam int unsigned IDCODE_WIDTH   = 32;
    localparam int unsigned CTRL_TDR_WIDTH = 16;

    typedef logic [IDCODE_WIDTH-1:0]   idcode_t;
    typedef logic [CTRL_TDR_WIDTH-1:0] ctrl_tdr_t;

    // --------------------
    // IDCODE fields
    // --------------------

    localparam logic [3:0]  ID_VERSION  = 4'h1;
    localparam logic [15:0] ID_PART     = 16'h5a3c;
    localparam logic [10:0] ID_MANUF    = 11'h2b5;

    // Bit 0 is fixed at one by the standard
    localparam idcode_t IDCODE_VALUE = {ID_VERSION, ID_PART, ID_MANUF, 1'b1};

endpackage

// File: common/tap_pkg.sv
package tap_pkg;

    // --------------------
    // Controller states
    // --------------------

    // Classic 1149.1 state encoding, four bits
    typedef enum logic [3:0] {
        ST_TLR        = 4'hf,
        ST_RTI        = 4'hc,
        ST_SEL_DR     = 4'h7,
        ST_CAPTURE_DR = 4'h6,
        ST_SHIFT_DR   = 4'h2,
        ST_EXIT1_DR   = 4'h1,
        ST_PAUSE_DR   = 4'h3,
        ST_EXIT2_DR   = 4'h0,
        ST_UPDATE_DR  = 4'h5,
        ST_SEL_IR     = 4'h4,
        ST_CAPTURE_IR = 4'he,
        ST_SHIFT_IR   = 4'ha,
        ST_EXIT1_IR   = 4'h9,
        ST_PAUSE_IR   = 4'hb,
        ST_EXIT2_IR   = 4'h8,
        ST_UPDATE_IR  = 4'hd
    } tap_state_t;

    // --------------------
    // Instruction register
    // --------------------

    localparam int unsigned IR_WIDTH = 4;

    typedef logic [IR_WIDTH-1:0] ir_t;

    // Opcodes, anything not listed falls back to bypass
    localparam ir_t OP_IDCODE   = 4'h2;
    localparam ir_t OP_CTRL_TDR = 4'h5;
    localparam ir_t OP_BYPASS   = '1;

    // Two LSBs must read 01 on Capture-IR
    localparam ir_t IR_CAPTURE = 4'b0001;

endpackage
